// File: logic/video_defines.svh
// Video raster geometry, pixel divider and sync pulse lengths shared by the design
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Width of every raster counter, enough for 1024 pixels or lines
`define VID_CNTW        10

// System clocks per pixel enable
`define VID_PXL_DIV     2

// Horizontal geometry, in pixels
`define VID_H_TOTAL     64
`define VID_H_ACTIVE    48
`define VID_HS_START    52
`define VID_HS_LEN      6

// Vertical geometry, in lines
`define VID_V_TOTAL     32
`define VID_V_ACTIVE    24
`define VID_VS_START    26
`define VID_VS_LEN      2

// Hold lengths of the regenerated pulses, in pixels and in hsync pulses
`define VID_HS_OUT_LEN  8
`define VID_VS_OUT_LEN  2

`endif

// File: logic/video_types_pkg.sv
// Raster types for pixel and line positions and for signed sync shifts
`default_nettype none

`include "video_defines.svh"

package video_types_pkg;

    // Offsets are four bit two's complement, so -8 to +7
    localparam int OFFSET_W = 4;

    // A pixel position within a line or a line position within a frame
    typedef logic [`VID_CNTW-1:0] raster_pos_t;

    // Shift applied to a sync pulse, in pixels for hsync and in lines for vsync
    // The sign bit is the MSB and is extended by the user to the raster width
    typedef logic [OFFSET_W-1:0] sync_offset_t;

endpackage : video_types_pkg

`default_nettype wire

// File: logic/adjust_pkg.sv
// Host adjustment types for the offset update controller
`default_nettype none

package adjust_pkg;

    // Both offsets are kept together in one register, horizontal in the upper half
    localparam int OFFSET_PAIR_W = 2 * $bits(video_types_pkg::sync_offset_t);

    typedef logic [OFFSET_PAIR_W-1:0] offset_pair_t;

    // Four-phase handshake controller states
    typedef enum logic [1:0] {
        idle       = 2'd0,  // Waiting for the host to raise adj_req
        wait_frame = 2'd1,  // Request seen, waiting for the lvbl falling edge
        hold_ack   = 2'd2   // Offsets applied, ack held until adj_req drops
    } adjust_state_t;

endpackage : adjust_pkg

`default_nettype wire

// File: logic/video_timing.sv
// Video timing generator with pixel enable, blanking and original sync outputs
`timescale 1ns/1ps
`default_nettype none

`include "video_defines.svh"

module video_timing (
    input  logic clk,
    input  logic rst,
    output logic pxl_cen,
    output logic lhbl,
    output logic lvbl,
    output logic hs_raw,
    output logic vs_raw
);

    import video_types_pkg::*;

    // A divider of one still needs a one bit counter
    localparam int DIVW = (`VID_PXL_DIV > 1) ? $clog2(`VID_PXL_DIV) : 1;

    logic [DIVW-1:0] div_cnt;  // Counts system clocks within one pixel
    raster_pos_t     h_cnt;    // Current pixel in the line
    raster_pos_t     v_cnt;    // Current line in the frame
    raster_pos_t     h_nxt;
    raster_pos_t     v_nxt;

    // Pixel enable is registered so it is a clean one clock pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= (div_cnt == DIVW'(`VID_PXL_DIV - 1));
            if (div_cnt == DIVW'(`VID_PXL_DIV - 1))
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    // Next raster position, vertical steps only when the line wraps
    always_comb begin
        h_nxt = (h_cnt == raster_pos_t'(`VID_H_TOTAL - 1)) ? '0 : h_cnt + 1'b1;
        v_nxt = v_cnt;
        if (h_cnt == raster_pos_t'(`VID_H_TOTAL - 1)) begin
            v_nxt = (v_cnt == raster_pos_t'(`VID_V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end
    end

    // Blanking and sync compare the next position so they line up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt  <= '0;
            v_cnt  <= '0;
            lhbl   <= 1'b1;  // Position 0,0 is visible
            lvbl   <= 1'b1;
            hs_raw <= 1'b0;
            vs_raw <= 1'b0;
        end else if (pxl_cen) begin
            h_cnt  <= h_nxt;
            v_cnt  <= v_nxt;
            lhbl   <= (h_nxt < raster_pos_t'(`VID_H_ACTIVE));
            lvbl   <= (v_nxt < raster_pos_t'(`VID_V_ACTIVE));
            hs_raw <= (h_nxt >= raster_pos_t'(`VID_HS_START)) &&
                      (h_nxt <  raster_pos_t'(`VID_HS_START + `VID_HS_LEN));
            vs_raw <= (v_nxt >= raster_pos_t'(`VID_VS_START)) &&
                      (v_nxt <  raster_pos_t'(`VID_VS_START + `VID_VS_LEN));
        end
    end

    // Every raster register downstream relies on the enable being a single clock wide
    a_cen_single: assert property (@(posedge clk) disable iff (rst) pxl_cen |=> !pxl_cen)
        else $error("pxl_cen high on two consecutive clocks");

endmodule : video_timing

`default_nettype wire

// File: logic/sync_reposition.sv
// Sync repositioning that measures original sync and regenerates shifted pulses
`timescale 1ns/1ps
`default_nettype none

`include "video_defines.svh"

module sync_reposition (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic                          lhbl,
    input  logic                          lvbl,
    input  logic                          hs_in,
    input  logic                          vs_in,
    input  video_types_pkg::sync_offset_t hoffset,
    input  video_types_pkg::sync_offset_t voffset,
    output logic                          hs_out,
    output logic                          vs_out
);

    import video_types_pkg::*;

    raster_pos_t hs_cnt;   // Pixels since the start of the visible line
    raster_pos_t vs_cnt;   // Lines since the start of the visible frame
    raster_pos_t vs_nxt;   // Value vs_cnt takes at this enable
    raster_pos_t hs_pos;   // Where the original hsync was last seen
    raster_pos_t vs_pos;   // Where the original vsync was last seen
    raster_pos_t htrip;    // Pixel that fires the regenerated hsync
    raster_pos_t vtrip;    // Line that fires the regenerated vsync
    logic        last_lhbl;
    logic        last_lvbl;
    logic        last_hs;
    logic        last_vs;
    logic        hb_edge;
    logic        vb_edge;
    logic        hs_edge;
    logic        vs_edge;
    logic [`VID_HS_OUT_LEN-1:0] hs_hold;  // Shifted right once per pixel
    logic [`VID_VS_OUT_LEN-1:0] vs_hold;  // Shifted right once per hsync

    // Rising edges, all judged against the value at the previous pixel enable
    assign hb_edge = lhbl  && !last_lhbl;
    assign vb_edge = lvbl  && !last_lvbl;
    assign hs_edge = hs_in && !last_hs;
    assign vs_edge = vs_in && !last_vs;

    // Offsets are sign extended so negative values move the pulse earlier
    assign htrip = hs_pos + {{(`VID_CNTW-OFFSET_W){hoffset[OFFSET_W-1]}}, hoffset};
    assign vtrip = vs_pos + {{(`VID_CNTW-OFFSET_W){voffset[OFFSET_W-1]}}, voffset};

    // The line count steps at the start of each visible line
    always_comb begin
        vs_nxt = vs_cnt;
        if (vb_edge)
            vs_nxt = '0;
        else if (hb_edge)
            vs_nxt = vs_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_lhbl <= 1'b0;  // First visible pixel after reset counts as an edge
            last_lvbl <= 1'b0;
            last_hs   <= 1'b0;
            last_vs   <= 1'b0;
            hs_cnt    <= '0;
            vs_cnt    <= '0;
            hs_pos    <= '0;
            vs_pos    <= '0;
            hs_hold   <= '0;
            vs_hold   <= '0;
            hs_out    <= 1'b0;
            vs_out    <= 1'b0;
        end else if (pxl_cen) begin
            last_lhbl <= lhbl;
            last_lvbl <= lvbl;
            last_hs   <= hs_in;
            last_vs   <= vs_in;
            hs_cnt    <= hb_edge ? '0 : hs_cnt + 1'b1;
            vs_cnt    <= vs_nxt;
            if (hs_edge) hs_pos <= hs_cnt;  // Latched pixel is one before the hsync pixel
            if (vs_edge) vs_pos <= vs_nxt;  // vsync starts with a line, so take the new count
            if (hs_cnt == htrip) begin
                hs_out  <= 1'b1;
                hs_hold <= '1;
                // vsync only changes on a regenerated hsync, so both rise together
                if (vs_cnt == vtrip) begin
                    vs_out  <= 1'b1;
                    vs_hold <= '1;
                end else begin
                    vs_hold <= vs_hold >> 1;
                    if (!vs_hold[0]) vs_out <= 1'b0;
                end
            end else begin
                hs_hold <= hs_hold >> 1;
                if (!hs_hold[0]) hs_out <= 1'b0;  // Falls one pixel after the hold empties
            end
        end
    end

    // A regenerated vsync must start on a regenerated hsync
    a_vs_on_hs: assert property (@(posedge clk) disable iff (rst) $rose(vs_out) |-> hs_out)
        else $error("vs_out rose while hs_out was low");

endmodule : sync_reposition

`default_nettype wire

// File: logic/adjust_ctrl.sv
// Host offset controller with four-phase req/ack and update at vertical blanking
`timescale 1ns/1ps
`default_nettype none

module adjust_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic                          lvbl,
    input  logic                          adj_req,
    input  video_types_pkg::sync_offset_t adj_h,
    input  video_types_pkg::sync_offset_t adj_v,
    output logic                          adj_ack,
    output video_types_pkg::sync_offset_t hoffset,
    output video_types_pkg::sync_offset_t voffset
);

    import adjust_pkg::*;

    adjust_state_t state;
    offset_pair_t  offs;       // Horizontal offset in the upper half
    logic          last_lvbl;  // lvbl as seen at the previous pixel enable
    logic          vb_fall;

    // Start of vertical blanking, seen only on a pixel enable
    assign vb_fall = pxl_cen && last_lvbl && !lvbl;

    assign hoffset = offs[OFFSET_PAIR_W-1 -: OFFSET_PAIR_W/2];
    assign voffset = offs[OFFSET_PAIR_W/2-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            last_lvbl <= 1'b1;
        end else if (pxl_cen) begin
            last_lvbl <= lvbl;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            offs    <= '0;
            adj_ack <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (adj_req) state <= wait_frame;  // Host offsets are stable from here
                end
                wait_frame: begin
                    // Applying at the blanking edge keeps every frame consistent
                    if (vb_fall) begin
                        offs    <= {adj_h, adj_v};
                        adj_ack <= 1'b1;
                        state   <= hold_ack;
                    end
                end
                hold_ack: begin
                    if (!adj_req) begin
                        adj_ack <= 1'b0;  // Host may start a new request after this
                        state   <= idle;
                    end
                end
                default: begin
                    adj_ack <= 1'b0;
                    state   <= idle;
                end
            endcase
        end
    end

    // Offsets may only change on the way into hold_ack
    a_offs_idle: assert property (@(posedge clk) disable iff (rst)
        (state == idle) |-> $stable(offs))
        else $error("offsets changed while the controller was idle");

endmodule : adjust_ctrl

`default_nettype wire

// File: logic/video_sync_top.sv
// Video sync subsystem top joining timing, offset control and sync repositioning
`timescale 1ns/1ps
`default_nettype none

module video_sync_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          adj_req,
    input  video_types_pkg::sync_offset_t adj_h,
    input  video_types_pkg::sync_offset_t adj_v,
    output logic                          adj_ack,
    output logic                          pxl_cen,
    output logic                          lhbl,
    output logic                          lvbl,
    output logic                          hs_raw,
    output logic                          vs_raw,
    output logic                          hs_out,
    output logic                          vs_out
);

    import video_types_pkg::*;

    sync_offset_t hoffset;  // Offsets in use, changed only at vertical blanking
    sync_offset_t voffset;

    // Raster source, also the reference sync for the host
    video_timing u_timing (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .hs_raw  (hs_raw),
        .vs_raw  (vs_raw)
    );

    adjust_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .lvbl    (lvbl),
        .adj_req (adj_req),
        .adj_h   (adj_h),
        .adj_v   (adj_v),
        .adj_ack (adj_ack),
        .hoffset (hoffset),
        .voffset (voffset)
    );

    sync_reposition u_resync (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .hs_in   (hs_raw),
        .vs_in   (vs_raw),
        .hoffset (hoffset),
        .voffset (voffset),
        .hs_out  (hs_out),
        .vs_out  (vs_out)
    );

endmodule : video_sync_top

`default_nettype wire

// File: tb/tb_video_sync.sv
// Directed testbench for the video sync subsystem covering raster, handshake and sync shifts
`timescale 1ns/1ps
`default_nettype none

`include "video_defines.svh"

module tb_video_sync;

    import video_types_pkg::*;

    localparam int FRAME_CLKS  = `VID_H_TOTAL * `VID_V_TOTAL * `VID_PXL_DIV;
    localparam int TEST_COUNT  = 5;
    localparam int CYCLE_LIMIT = FRAME_CLKS * 6 * TEST_COUNT;  // Six frames for every test
    localparam int HS_WIDTH    = `VID_HS_OUT_LEN + 1;  // Regenerated hsync in pixel enables

    logic         clk = 1'b0;
    logic         rst;
    logic         adj_req;
    sync_offset_t adj_h;
    sync_offset_t adj_v;
    logic         adj_ack;
    logic         pxl_cen;
    logic         lhbl;
    logic         lvbl;
    logic         hs_raw;
    logic         vs_raw;
    logic         hs_out;
    logic         vs_out;
    int           seed   = 41422;
    int           cycles = 0;

    // One sample per pixel, taken on the falling edge just before each pixel enable
    logic s_lhbl, l_lhbl;
    logic s_lvbl, l_lvbl;
    logic s_hs_raw, l_hs_raw;
    logic s_vs_raw, l_vs_raw;
    logic s_hs_out, l_hs_out;
    logic s_vs_out, l_vs_out;

    always #2 clk = ~clk;  // 4 ns clock

    video_sync_top dut (
        .clk     (clk),
        .rst     (rst),
        .adj_req (adj_req),
        .adj_h   (adj_h),
        .adj_v   (adj_v),
        .adj_ack (adj_ack),
        .pxl_cen (pxl_cen),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .hs_raw  (hs_raw),
        .vs_raw  (vs_raw),
        .hs_out  (hs_out),
        .vs_out  (vs_out)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            abort_run($sformatf("timeout, no verdict after %0d clock cycles", cycles));
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_int(input string what, input int got, input int exp);
        assert (got == exp) else
            abort_run($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp) else
            abort_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // Steps to the next pixel, keeping the previous sample for edge detection
    task automatic next_pixel;
        l_lhbl   = s_lhbl;
        l_lvbl   = s_lvbl;
        l_hs_raw = s_hs_raw;
        l_vs_raw = s_vs_raw;
        l_hs_out = s_hs_out;
        l_vs_out = s_vs_out;
        do @(negedge clk); while (!pxl_cen);
        s_lhbl   = lhbl;
        s_lvbl   = lvbl;
        s_hs_raw = hs_raw;
        s_vs_raw = vs_raw;
        s_hs_out = hs_out;
        s_vs_out = vs_out;
    endtask

    // The first step only refreshes the previous sample after a gap
    task automatic wait_lhbl_rise;
        next_pixel();
        do next_pixel(); while (!(s_lhbl && !l_lhbl));
    endtask

    task automatic wait_lvbl_rise;
        next_pixel();
        do next_pixel(); while (!(s_lvbl && !l_lvbl));
    endtask

    // Clocks from one pixel enable to the next, over a few enables
    task automatic check_cen_period;
        int n;
        do @(negedge clk); while (!pxl_cen);
        repeat (4) begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!pxl_cen);
            check_int("clocks per pixel enable", n, `VID_PXL_DIV);
        end
    endtask

    // Returns on the falling edge where adj_ack reaches the level
    task automatic wait_ack(input logic level, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit)
                abort_run($sformatf("adj_ack did not go to %0d within %0d clock cycles",
                                    level, limit));
        end while (adj_ack !== level);
    endtask

    // One full four-phase transfer, the ack can take up to a frame
    task automatic apply_offsets(input int h, input int v);
        @(negedge clk);
        adj_h   = sync_offset_t'(h);
        adj_v   = sync_offset_t'(v);
        adj_req = 1'b1;
        wait_ack(1'b1, FRAME_CLKS + 4 * `VID_PXL_DIV);
        adj_req = 1'b0;
        wait_ack(1'b0, 1);  // Ack drops on the very next clock
    endtask

    // Pixel positions of the hs_raw and hs_out rises within one line, plus hs_out width
    task automatic measure_hlag(output int lag, output int width);
        int px;
        int raw_at;
        int out_at;
        px     = 0;
        raw_at = -1;
        out_at = -1;
        wait_lhbl_rise();
        forever begin
            next_pixel();
            px++;
            if (s_hs_raw && !l_hs_raw) raw_at = px;
            if (s_hs_out && !l_hs_out) out_at = px;
            if (l_hs_out && !s_hs_out && out_at >= 0 && raw_at >= 0) break;  // Pulse tail seen
        end
        lag   = out_at - raw_at;
        width = px - out_at;
    endtask

    task automatic reset_dut;
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        check_bit("adj_ack after reset", adj_ack, 1'b0);
        check_bit("hs_out after reset", hs_out, 1'b0);
        check_bit("vs_out after reset", vs_out, 1'b0);
    endtask

    task automatic test_raster;
        int px;
        int hi;
        int lines;
        int vis;
        check_cen_period();
        wait_lvbl_rise();  // Now on the first pixel of a frame
        px    = 0;
        hi    = s_lhbl ? 1 : 0;
        lines = 1;
        vis   = 1;
        forever begin
            next_pixel();
            if (s_lvbl && !l_lvbl) break;
            if (s_lhbl && !l_lhbl) begin
                if (lines == 1) begin
                    check_int("line period in pixel enables", px + 1, `VID_H_TOTAL);
                    check_int("lhbl high time in pixel enables", hi, `VID_H_ACTIVE);
                end
                lines++;
                if (s_lvbl) vis++;
                px = 0;
                hi = 0;
            end else begin
                px++;
            end
            if (s_lhbl) hi++;
            // px is the pixel and lines-1 the line of this sample
            if (s_hs_raw && !l_hs_raw)
                check_int("hs_raw start pixel", px, `VID_HS_START);
            if (l_hs_raw && !s_hs_raw)
                check_int("hs_raw end pixel", px, `VID_HS_START + `VID_HS_LEN);
            if (s_vs_raw && !l_vs_raw)
                check_int("vs_raw start line", lines - 1, `VID_VS_START);
            if (l_vs_raw && !s_vs_raw)
                check_int("vs_raw end line", lines - 1, `VID_VS_START + `VID_VS_LEN);
        end
        check_int("lines per frame", lines, `VID_V_TOTAL);
        check_int("visible lines per frame", vis, `VID_V_ACTIVE);
    endtask

    task automatic test_zero_offset;
        int lag;
        int width;
        wait_lvbl_rise();  // Settle frame so the sync position has been measured
        measure_hlag(lag, width);
        check_int("hs_out lag at zero offset", lag, 1);
        check_int("hs_out width at zero offset", width, HS_WIDTH);
    endtask

    task automatic test_handshake;
        logic seen_fall;
        wait_lvbl_rise();
        repeat (4) wait_lhbl_rise();  // Well inside active video
        @(negedge clk);
        adj_h     = '0;
        adj_v     = '0;
        adj_req   = 1'b1;
        seen_fall = 1'b0;
        while (!seen_fall) begin
            @(negedge clk);
            check_bit("adj_ack before the blanking edge", adj_ack, 1'b0);
            if (!lvbl) seen_fall = 1'b1;
        end
        wait_ack(1'b1, 2 * `VID_PXL_DIV);
        repeat (8) begin
            @(negedge clk);
            check_bit("adj_ack while adj_req is held", adj_ack, 1'b1);
        end
        adj_req = 1'b0;
        @(negedge clk);
        check_bit("adj_ack one clock after adj_req drops", adj_ack, 1'b0);
    endtask

    task automatic test_hshift;
        int hvals [5];
        int lag;
        int width;
        int i;
        hvals[0] = 7;
        hvals[1] = -8;
        for (i = 2; i < 5; i++)
            hvals[i] = ($random(seed) & 15) - 8;  // Any four bit offset
        for (i = 0; i < 5; i++) begin
            apply_offsets(hvals[i], 0);
            wait_lvbl_rise();
            measure_hlag(lag, width);
            check_int("hs_out lag behind hs_raw", lag, hvals[i] + 1);
            check_int("hs_out width", width, HS_WIDTH);
        end
    endtask

    // Lines count from the lvbl rise and step on every lhbl rise
    task automatic check_vshift(input int voff);
        int   line;
        int   raw_line;
        int   out_line;
        int   pulses;
        logic out_done;
        line     = 0;
        raw_line = -1;
        out_line = -1;
        pulses   = 0;
        out_done = 1'b0;
        wait_lvbl_rise();
        forever begin
            next_pixel();
            if (s_lvbl && !l_lvbl) line = 0;
            else if (s_lhbl && !l_lhbl) line++;
            if (s_vs_raw && !l_vs_raw && raw_line < 0) raw_line = line;
            if (s_vs_out && !l_vs_out && out_line < 0) begin
                out_line = line;
                check_bit("hs_out rising with vs_out", s_hs_out && !l_hs_out, 1'b1);
            end
            if (out_line >= 0 && s_hs_out && !l_hs_out && s_vs_out) pulses++;
            if (out_line >= 0 && l_vs_out && !s_vs_out) out_done = 1'b1;
            if (out_done && raw_line >= 0) break;
        end
        check_int("vs_out line shift", out_line - raw_line, voff);
        check_int("vs_out length in hsync pulses", pulses, `VID_VS_OUT_LEN + 1);
    endtask

    task automatic test_vshift;
        int vvals [4];
        int i;
        vvals[0] = 2;
        vvals[1] = 5;   // Last line of the frame still reachable
        vvals[2] = -3;
        vvals[3] = -8;
        for (i = 0; i < 4; i++) begin
            apply_offsets(3, vvals[i]);  // A nonzero hsync shift moves the vsync edge with it
            check_vshift(vvals[i]);
        end
    endtask

    initial begin
        rst     = 1'b1;
        adj_req = 1'b0;
        adj_h   = '0;
        adj_v   = '0;
        reset_dut();
        test_raster();
        test_zero_offset();
        test_handshake();
        test_hshift();
        test_vshift();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : tb_video_sync

`default_nettype wire

// File: compile.f
+incdir+logic
logic/video_types_pkg.sv
logic/adjust_pkg.sv
logic/video_timing.sv
logic/sync_reposition.sv
logic/adjust_ctrl.sv
logic/video_sync_top.sv
tb/tb_video_sync.sv

// File: Makefile
# Verilator build and run of the video sync testbench
TOP := tb_video_sync

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module $(TOP) \
		-f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
